/* hdl/rename_config.svh */
// Widths and sizes for the rename and dispatch stage
// Included by the package and by every RTL file that sizes its ports
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// Instructions renamed per cycle
`define DISP_WIDTH 2

// Register file sizes
`define ARCH_REGS 32
`define PHYS_REGS 64

// Window sizes
`define ROB_SIZE 32
`define RS_SIZE 16

// PC width
`define XLEN 32

`endif

/* hdl/rename_pkg.sv */
// Shared types for the rename and dispatch stage
// Imported by every block that builds or reads bundles and records
`include "rename_config.svh"

package rename_pkg;

    typedef logic [$clog2(`ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(`PHYS_REGS)-1:0] phys_tag_t;
    typedef logic [$clog2(`ROB_SIZE)-1:0] rob_idx_t;
    typedef logic [$clog2(`ROB_SIZE+1)-1:0] rob_count_t;
    typedef logic [$clog2(`RS_SIZE+1)-1:0] rs_count_t;
    typedef logic [$clog2(`PHYS_REGS-`ARCH_REGS+1)-1:0] fl_count_t;
    typedef logic [`DISP_WIDTH-1:0] lane_mask_t;
    typedef logic [$clog2(`DISP_WIDTH+1)-1:0] lane_count_t;

    // Functional unit class from decode
    typedef enum logic [2:0] {
        OP_ALU,
        OP_MUL,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH
    } op_class_e;

    ////////////////////////////////////////
    // Fetch side
    ////////////////////////////////////////
    typedef struct packed {
        logic valid;
        logic [`XLEN-1:0] pc;
        op_class_e op_class;
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
        logic uses_rd;
        logic uses_rs1;
        logic uses_rs2;
    } fetch_inst_t;

    typedef fetch_inst_t [`DISP_WIDTH-1:0] fetch_bundle_t;

    ////////////////////////////////////////
    // Allocation records
    ////////////////////////////////////////
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        op_class_e op_class;
        logic is_branch;
        arch_reg_t arch_rd;
        logic uses_rd;
        phys_tag_t phys_rd;
        phys_tag_t prev_phys_rd;
    } rob_entry_t;

    typedef struct packed {
        op_class_e op_class;
        phys_tag_t src1_tag;
        logic src1_ready;
        phys_tag_t src2_tag;
        logic src2_ready;
        phys_tag_t dest_tag;
        rob_idx_t rob_idx;
    } rs_entry_t;

    // Commit port, oldest lane first
    typedef struct packed {
        logic valid;
        logic uses_rd;
        arch_reg_t arch_rd;
        phys_tag_t phys_rd;
        phys_tag_t prev_phys_rd;
    } retire_lane_t;

    typedef retire_lane_t [`DISP_WIDTH-1:0] retire_bundle_t;

    // Number of set lanes in a mask
    function automatic lane_count_t count_lanes(input lane_mask_t mask);
        lane_count_t n;
        n = '0;
        for (int i = 0; i < `DISP_WIDTH; i++) begin
            n = n + lane_count_t'(mask[i]);
        end
        return n;
    endfunction

endpackage

/* hdl/map_table.sv */
// Speculative and committed register maps for renaming
// Reads are combinational, rename and retire writes land at the clock edge
`timescale 1ns/1ns
`include "rename_config.svh"

module map_table (
    input  logic clock,
    input  logic reset,
    // Three reads per lane: rs1, rs2, rd
    input  rename_pkg::arch_reg_t [3*`DISP_WIDTH-1:0] read_idx,
    output rename_pkg::phys_tag_t [3*`DISP_WIDTH-1:0] read_tag,
    // Rename writes from dispatch
    input  rename_pkg::lane_mask_t write_en,
    input  rename_pkg::arch_reg_t [`DISP_WIDTH-1:0] write_idx,
    input  rename_pkg::phys_tag_t [`DISP_WIDTH-1:0] write_tag,
    input  rename_pkg::retire_bundle_t retire_bundle,
    input  logic mispredict
);
    import rename_pkg::*;

    phys_tag_t spec_map [`ARCH_REGS];
    phys_tag_t commit_map [`ARCH_REGS];
    // Committed map with this cycle's retires applied
    phys_tag_t commit_next [`ARCH_REGS];

    // Speculative lookups, no in-bundle bypass here
    always_comb begin
        for (int i = 0; i < 3*`DISP_WIDTH; i++) begin
            read_tag[i] = spec_map[read_idx[i]];
        end
    end

    // Retire lanes in order, so a younger retire of the same reg wins
    always_comb begin
        for (int r = 0; r < `ARCH_REGS; r++) begin
            commit_next[r] = commit_map[r];
        end
        for (int i = 0; i < `DISP_WIDTH; i++) begin
            if (retire_bundle[i].valid && retire_bundle[i].uses_rd) begin
                commit_next[retire_bundle[i].arch_rd] = retire_bundle[i].phys_rd;
            end
        end
    end

    ////////////////////////////////////////
    // Table update
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            // Identity map out of reset
            for (int r = 0; r < `ARCH_REGS; r++) begin
                spec_map[r] <= phys_tag_t'(r);
                commit_map[r] <= phys_tag_t'(r);
            end
        end else begin
            for (int r = 0; r < `ARCH_REGS; r++) begin
                commit_map[r] <= commit_next[r];
            end
            if (mispredict) begin
                // Full flush, speculative state becomes the retired state
                for (int r = 0; r < `ARCH_REGS; r++) begin
                    spec_map[r] <= commit_next[r];
                end
            end else begin
                // Later lane overwrites an earlier write to the same reg
                for (int i = 0; i < `DISP_WIDTH; i++) begin
                    if (write_en[i]) begin
                        spec_map[write_idx[i]] <= write_tag[i];
                    end
                end
            end
        end
    end

endmodule

/* hdl/free_list.sv */
// Circular list of free physical tags for destination renaming
// Dispatch pops at the speculative head, retire pushes old tags at the tail
`timescale 1ns/1ns
`include "rename_config.svh"

module free_list (
    input  logic clock,
    input  logic reset,
    input  rename_pkg::lane_mask_t pop,
    output rename_pkg::phys_tag_t [`DISP_WIDTH-1:0] head_tag,
    output rename_pkg::fl_count_t count,
    input  rename_pkg::retire_bundle_t retire_bundle,
    input  logic mispredict
);
    import rename_pkg::*;

    localparam int FL_SIZE = `PHYS_REGS - `ARCH_REGS;
    localparam int IDX_W = $clog2(FL_SIZE);

    // Extra top bit tells a full list from an empty one
    typedef logic [IDX_W:0] fl_ptr_t;

    phys_tag_t tag_buf [FL_SIZE];
    fl_ptr_t spec_head;
    fl_ptr_t commit_head;
    fl_ptr_t tail;

    lane_mask_t push_mask;
    fl_ptr_t push_ptr [`DISP_WIDTH];
    fl_ptr_t tail_next;
    fl_ptr_t commit_head_next;

    // Tags visible to dispatch, next in line first
    always_comb begin
        for (int i = 0; i < `DISP_WIDTH; i++) begin
            head_tag[i] = tag_buf[IDX_W'(spec_head + fl_ptr_t'(i))];
        end
    end

    // Entries between the speculative head and the tail
    assign count = fl_count_t'(tail - spec_head);

    ////////////////////////////////////////
    // Retire pushes
    ////////////////////////////////////////
    // Each freed tag takes the next slot at the tail in lane order
    always_comb begin
        fl_ptr_t ptr;
        ptr = tail;
        for (int i = 0; i < `DISP_WIDTH; i++) begin
            push_mask[i] = retire_bundle[i].valid && retire_bundle[i].uses_rd;
            push_ptr[i] = ptr;
            if (push_mask[i]) begin
                ptr = ptr + 1'b1;
            end
        end
        tail_next = ptr;
    end

    // Every committed rd consumed one tag off the committed head
    assign commit_head_next = commit_head + fl_ptr_t'(count_lanes(push_mask));

    always_ff @(posedge clock) begin
        if (reset) begin
            // Tags above the architectural range start out free, in order
            for (int i = 0; i < FL_SIZE; i++) begin
                tag_buf[i] <= phys_tag_t'(`ARCH_REGS + i);
            end
            spec_head <= '0;
            commit_head <= '0;
            tail <= fl_ptr_t'(FL_SIZE);
        end else begin
            for (int i = 0; i < `DISP_WIDTH; i++) begin
                if (push_mask[i]) begin
                    tag_buf[push_ptr[i][IDX_W-1:0]] <= retire_bundle[i].prev_phys_rd;
                end
            end
            tail <= tail_next;
            commit_head <= commit_head_next;
            // Flush hands back every tag popped since the last commit
            if (mispredict) begin
                spec_head <= commit_head_next;
            end else begin
                spec_head <= spec_head + fl_ptr_t'(count_lanes(pop));
            end
        end
    end

endmodule

/* hdl/rob_tracker.sv */
// ROB head, tail and occupancy bookkeeping for dispatch
// Gives dispatch the next ROB index and the number of free slots
`timescale 1ns/1ns
`include "rename_config.svh"

module rob_tracker (
    input  logic clock,
    input  logic reset,
    input  rename_pkg::lane_mask_t dispatch_mask,
    input  rename_pkg::retire_bundle_t retire_bundle,
    input  logic mispredict,
    output rename_pkg::rob_idx_t rob_tail,
    output rename_pkg::rob_count_t rob_free
);
    import rename_pkg::*;

    rob_idx_t head;
    rob_idx_t head_next;
    rob_count_t occupancy;
    lane_mask_t retire_mask;
    lane_count_t n_disp;
    lane_count_t n_retire;

    always_comb begin
        for (int i = 0; i < `DISP_WIDTH; i++) begin
            retire_mask[i] = retire_bundle[i].valid;
        end
    end

    assign n_disp = count_lanes(dispatch_mask);
    assign n_retire = count_lanes(retire_mask);
    assign head_next = head + rob_idx_t'(n_retire);

    assign rob_free = rob_count_t'(`ROB_SIZE) - occupancy;

    // Indices wrap with the 5-bit pointers
    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            rob_tail <= '0;
            occupancy <= '0;
        end else begin
            head <= head_next;
            if (mispredict) begin
                // Everything younger than the retired point is gone
                rob_tail <= head_next;
                occupancy <= '0;
            end else begin
                rob_tail <= rob_tail + rob_idx_t'(n_disp);
                occupancy <= occupancy + rob_count_t'(n_disp) - rob_count_t'(n_retire);
            end
        end
    end

endmodule

/* hdl/dispatch_stage.sv */
// Atomic dispatch of one fetch bundle with in-bundle rename bypass
// Builds ROB and RS allocation records combinationally from the map and free list
`timescale 1ns/1ns
`include "rename_config.svh"

module dispatch_stage (
    input  rename_pkg::fetch_bundle_t fetch_bundle,
    input  rename_pkg::rs_count_t rs_free_slots,
    input  logic mispredict,
    // Map table lookup and rename write
    output rename_pkg::arch_reg_t [3*`DISP_WIDTH-1:0] map_idx,
    input  rename_pkg::phys_tag_t [3*`DISP_WIDTH-1:0] map_tag,
    output rename_pkg::lane_mask_t map_we,
    output rename_pkg::arch_reg_t [`DISP_WIDTH-1:0] map_wr_idx,
    output rename_pkg::phys_tag_t [`DISP_WIDTH-1:0] map_wr_tag,
    // Free list
    output rename_pkg::lane_mask_t fl_pop,
    input  rename_pkg::phys_tag_t [`DISP_WIDTH-1:0] fl_tag,
    input  rename_pkg::fl_count_t fl_count,
    // ROB bookkeeping
    input  rename_pkg::rob_idx_t rob_tail,
    input  rename_pkg::rob_count_t rob_free,
    output logic stall,
    output rename_pkg::lane_mask_t dispatch_mask,
    output rename_pkg::rob_entry_t [`DISP_WIDTH-1:0] rob_alloc,
    output rename_pkg::rs_entry_t [`DISP_WIDTH-1:0] rs_alloc
);
    import rename_pkg::*;

    lane_mask_t valid_mask;
    lane_mask_t rd_mask;
    lane_count_t n_valid;
    lane_count_t n_rd;

    phys_tag_t [`DISP_WIDTH-1:0] src1_tag;
    phys_tag_t [`DISP_WIDTH-1:0] src2_tag;
    phys_tag_t [`DISP_WIDTH-1:0] prev_tag;
    phys_tag_t [`DISP_WIDTH-1:0] new_tag;
    rob_idx_t [`DISP_WIDTH-1:0] lane_rob_idx;

    ////////////////////////////////////////
    // Stall decision
    ////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < `DISP_WIDTH; i++) begin
            valid_mask[i] = fetch_bundle[i].valid;
            rd_mask[i] = fetch_bundle[i].valid && fetch_bundle[i].uses_rd;
        end
    end

    assign n_valid = count_lanes(valid_mask);
    assign n_rd = count_lanes(rd_mask);

    // All or nothing, every valid lane must fit everywhere
    assign stall = |valid_mask && (rob_free < rob_count_t'(n_valid)
                                   || rs_free_slots < rs_count_t'(n_valid)
                                   || fl_count < fl_count_t'(n_rd));

    // Nothing goes out in the flush cycle
    assign dispatch_mask = (stall || mispredict) ? '0 : valid_mask;

    // Only dispatched lanes with a destination consume a tag
    assign fl_pop = dispatch_mask & rd_mask;
    assign map_we = fl_pop;

    ////////////////////////////////////////
    // Rename
    ////////////////////////////////////////
    always_comb begin
        lane_count_t pop_pos;
        lane_count_t rob_ofs;
        pop_pos = '0;
        rob_ofs = '0;
        for (int i = 0; i < `DISP_WIDTH; i++) begin
            // Lookup slots 3i, 3i+1, 3i+2 are rs1, rs2, rd
            map_idx[3*i] = fetch_bundle[i].rs1;
            map_idx[3*i+1] = fetch_bundle[i].rs2;
            map_idx[3*i+2] = fetch_bundle[i].rd;
            src1_tag[i] = map_tag[3*i];
            src2_tag[i] = map_tag[3*i+1];
            prev_tag[i] = map_tag[3*i+2];
            // Older lanes in the bundle override the table, youngest of them wins
            for (int j = 0; j < i; j++) begin
                if (rd_mask[j] && fetch_bundle[j].rd == fetch_bundle[i].rs1) begin
                    src1_tag[i] = new_tag[j];
                end
                if (rd_mask[j] && fetch_bundle[j].rd == fetch_bundle[i].rs2) begin
                    src2_tag[i] = new_tag[j];
                end
                if (rd_mask[j] && fetch_bundle[j].rd == fetch_bundle[i].rd) begin
                    prev_tag[i] = new_tag[j];
                end
            end
            // Head tags are handed out to rd lanes in order
            new_tag[i] = rd_mask[i] ? fl_tag[pop_pos[$clog2(`DISP_WIDTH)-1:0]] : '0;
            if (rd_mask[i]) begin
                pop_pos = pop_pos + 1'b1;
            end
            // ROB slots are consecutive over dispatched lanes
            lane_rob_idx[i] = rob_tail + rob_idx_t'(rob_ofs);
            if (dispatch_mask[i]) begin
                rob_ofs = rob_ofs + 1'b1;
            end
            map_wr_idx[i] = fetch_bundle[i].rd;
            map_wr_tag[i] = new_tag[i];
        end
    end

    ////////////////////////////////////////
    // Allocation records
    ////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < `DISP_WIDTH; i++) begin
            rob_alloc[i].pc = fetch_bundle[i].pc;
            rob_alloc[i].op_class = fetch_bundle[i].op_class;
            rob_alloc[i].is_branch = fetch_bundle[i].op_class == OP_BRANCH;
            rob_alloc[i].arch_rd = fetch_bundle[i].rd;
            rob_alloc[i].uses_rd = fetch_bundle[i].uses_rd;
            rob_alloc[i].phys_rd = new_tag[i];
            // No old mapping to free without a destination
            rob_alloc[i].prev_phys_rd = fetch_bundle[i].uses_rd ? prev_tag[i] : '0;

            rs_alloc[i].op_class = fetch_bundle[i].op_class;
            // Unused sources read as ready on tag 0
            // Used ones wait, there is no busy table here
            rs_alloc[i].src1_tag = fetch_bundle[i].uses_rs1 ? src1_tag[i] : '0;
            rs_alloc[i].src1_ready = !fetch_bundle[i].uses_rs1;
            rs_alloc[i].src2_tag = fetch_bundle[i].uses_rs2 ? src2_tag[i] : '0;
            rs_alloc[i].src2_ready = !fetch_bundle[i].uses_rs2;
            rs_alloc[i].dest_tag = new_tag[i];
            rs_alloc[i].rob_idx = lane_rob_idx[i];
        end
    end

endmodule

/* hdl/rename_top.sv */
// Top level of the rename and dispatch stage
// Ties the map table, free list and ROB tracker to the dispatch logic
`timescale 1ns/1ns
`include "rename_config.svh"

module rename_top (
    input  logic clock,
    input  logic reset,
    input  rename_pkg::fetch_bundle_t fetch_bundle,
    input  rename_pkg::rs_count_t rs_free_slots,
    input  rename_pkg::retire_bundle_t retire_bundle,
    input  logic mispredict,
    output logic stall,
    output rename_pkg::lane_mask_t dispatch_mask,
    output rename_pkg::rob_entry_t [`DISP_WIDTH-1:0] rob_alloc,
    output rename_pkg::rs_entry_t [`DISP_WIDTH-1:0] rs_alloc
);
    import rename_pkg::*;

    // Map table paths
    arch_reg_t [3*`DISP_WIDTH-1:0] map_idx;
    phys_tag_t [3*`DISP_WIDTH-1:0] map_tag;
    lane_mask_t map_we;
    arch_reg_t [`DISP_WIDTH-1:0] map_wr_idx;
    phys_tag_t [`DISP_WIDTH-1:0] map_wr_tag;

    // Free list paths
    lane_mask_t fl_pop;
    phys_tag_t [`DISP_WIDTH-1:0] fl_tag;
    fl_count_t fl_count;

    // ROB bookkeeping
    rob_idx_t rob_tail;
    rob_count_t rob_free;

    map_table map_table_inst (
        .clock(clock),
        .reset(reset),
        .read_idx(map_idx),
        .read_tag(map_tag),
        .write_en(map_we),
        .write_idx(map_wr_idx),
        .write_tag(map_wr_tag),
        .retire_bundle(retire_bundle),
        .mispredict(mispredict)
    );

    free_list free_list_inst (
        .clock(clock),
        .reset(reset),
        .pop(fl_pop),
        .head_tag(fl_tag),
        .count(fl_count),
        .retire_bundle(retire_bundle),
        .mispredict(mispredict)
    );

    rob_tracker rob_tracker_inst (
        .clock(clock),
        .reset(reset),
        .dispatch_mask(dispatch_mask),
        .retire_bundle(retire_bundle),
        .mispredict(mispredict),
        .rob_tail(rob_tail),
        .rob_free(rob_free)
    );

    dispatch_stage dispatch_stage_inst (
        .fetch_bundle(fetch_bundle),
        .rs_free_slots(rs_free_slots),
        .mispredict(mispredict),
        .map_idx(map_idx),
        .map_tag(map_tag),
        .map_we(map_we),
        .map_wr_idx(map_wr_idx),
        .map_wr_tag(map_wr_tag),
        .fl_pop(fl_pop),
        .fl_tag(fl_tag),
        .fl_count(fl_count),
        .rob_tail(rob_tail),
        .rob_free(rob_free),
        .stall(stall),
        .dispatch_mask(dispatch_mask),
        .rob_alloc(rob_alloc),
        .rs_alloc(rs_alloc)
    );

endmodule

/* sim/rename_tb.sv */
// Random-stimulus testbench for the rename and dispatch stage
// A reference model of maps, free list and ROB checks every dispatched record
`timescale 1ns/1ns
`include "rename_config.svh"

module rename_tb;
    import rename_pkg::*;

    localparam int NUM_CYCLES = 3000;
    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 8;
    localparam int MARGIN_CYCLES = 50;

    logic clock;
    logic reset;
    fetch_bundle_t fetch_bundle;
    rs_count_t rs_free_slots;
    retire_bundle_t retire_bundle;
    logic mispredict;
    logic stall;
    lane_mask_t dispatch_mask;
    rob_entry_t [`DISP_WIDTH-1:0] rob_alloc;
    rs_entry_t [`DISP_WIDTH-1:0] rs_alloc;

    ////////////////////////////////////////
    // Reference model state
    ////////////////////////////////////////
    phys_tag_t spec_map [`ARCH_REGS];
    phys_tag_t commit_map [`ARCH_REGS];
    // Front of the queue is the committed head
    phys_tag_t fl_q [$];
    // Tags popped past the committed head
    int spec_ofs;
    // In-flight ROB records, oldest first
    rob_entry_t rob_q [$];
    rob_idx_t model_head;
    rob_idx_t model_tail;
    int ret_n;
    logic hold_bundle;
    int unsigned rng_state;

    rename_top rename_top_inst (
        .clock(clock),
        .reset(reset),
        .fetch_bundle(fetch_bundle),
        .rs_free_slots(rs_free_slots),
        .retire_bundle(retire_bundle),
        .mispredict(mispredict),
        .stall(stall),
        .dispatch_mask(dispatch_mask),
        .rob_alloc(rob_alloc),
        .rs_alloc(rs_alloc)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD/2) clock = ~clock;
    end

    // LCG, upper bits only since the low ones cycle quickly
    function automatic int unsigned next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state >> 8;
    endfunction

    // Half the time a small register range, to force in-bundle collisions
    function automatic arch_reg_t random_reg();
        if (next_rand() % 2 == 0) begin
            return arch_reg_t'(next_rand() % 4);
        end
        return arch_reg_t'(next_rand());
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "Run stopped on a failed check");
    endtask

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////
    task automatic compare_dispatch(input logic act_stall, input lane_mask_t act_mask,
                                    input logic exp_stall, input lane_mask_t exp_mask);
        if (act_stall !== exp_stall || act_mask !== exp_mask) begin
            stop_with_failure($sformatf(
                "Mismatch at %0t: stall %b mask %b, expected stall %b mask %b",
                $time, act_stall, act_mask, exp_stall, exp_mask));
        end
    endtask

    task automatic compare_rob_entry(input rob_entry_t act, input rob_entry_t exp, input int lane);
        if (act !== exp) begin
            stop_with_failure($sformatf(
                "Mismatch at %0t: lane %0d ROB record %h, expected %h",
                $time, lane, act, exp));
        end
    endtask

    task automatic compare_rs_entry(input rs_entry_t act, input rs_entry_t exp, input int lane);
        if (act !== exp) begin
            stop_with_failure($sformatf(
                "Mismatch at %0t: lane %0d RS record %h, expected %h",
                $time, lane, act, exp));
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    task automatic random_bundle(output fetch_bundle_t fb);
        for (int i = 0; i < `DISP_WIDTH; i++) begin
            fb[i].valid = (next_rand() % 4) != 0;
            fb[i].pc = (next_rand() << 16) ^ next_rand();
            fb[i].op_class = op_class_e'(next_rand() % 5);
            fb[i].rd = random_reg();
            fb[i].rs1 = random_reg();
            fb[i].rs2 = random_reg();
            fb[i].uses_rd = (next_rand() % 4) != 0;
            fb[i].uses_rs1 = (next_rand() % 4) != 0;
            fb[i].uses_rs2 = (next_rand() % 2) != 0;
        end
    endtask

    // Oldest in-flight records go out first, lanes filled from lane 0
    task automatic build_retire(output retire_bundle_t rb, output int n);
        int want;
        want = next_rand() % 3;
        if (want > rob_q.size()) begin
            want = rob_q.size();
        end
        rb = '0;
        for (int i = 0; i < want; i++) begin
            rb[i].valid = 1'b1;
            rb[i].uses_rd = rob_q[i].uses_rd;
            rb[i].arch_rd = rob_q[i].arch_rd;
            rb[i].phys_rd = rob_q[i].phys_rd;
            rb[i].prev_phys_rd = rob_q[i].prev_phys_rd;
        end
        n = want;
    endtask

    ////////////////////////////////////////
    // Check one cycle and advance the model
    ////////////////////////////////////////
    task automatic check_cycle();
        lane_mask_t valid_mask;
        lane_mask_t exp_mask;
        logic exp_stall;
        int n_valid;
        int n_rd;
        int rob_room;
        int fl_room;
        fetch_inst_t fi;
        phys_tag_t new_tag;
        rob_entry_t exp_rob;
        rs_entry_t exp_rs;
        rob_entry_t done;
        n_valid = 0;
        n_rd = 0;
        for (int i = 0; i < `DISP_WIDTH; i++) begin
            valid_mask[i] = fetch_bundle[i].valid;
            if (fetch_bundle[i].valid) begin
                n_valid++;
                if (fetch_bundle[i].uses_rd) begin
                    n_rd++;
                end
            end
        end
        rob_room = `ROB_SIZE - rob_q.size();
        fl_room = fl_q.size() - spec_ofs;
        // All valid lanes fit or the bundle waits
        exp_stall = (n_valid > 0) && (rob_room < n_valid || int'(rs_free_slots) < n_valid
                                      || fl_room < n_rd);
        exp_mask = (exp_stall || mispredict) ? '0 : valid_mask;
        compare_dispatch(stall, dispatch_mask, exp_stall, exp_mask);

        // Lanes renamed in order, so lane 1 sees lane 0's write in the map
        for (int i = 0; i < `DISP_WIDTH; i++) begin
            if (exp_mask[i]) begin
                fi = fetch_bundle[i];
                new_tag = fi.uses_rd ? fl_q[spec_ofs] : '0;
                exp_rob.pc = fi.pc;
                exp_rob.op_class = fi.op_class;
                exp_rob.is_branch = fi.op_class == OP_BRANCH;
                exp_rob.arch_rd = fi.rd;
                exp_rob.uses_rd = fi.uses_rd;
                exp_rob.phys_rd = new_tag;
                exp_rob.prev_phys_rd = fi.uses_rd ? spec_map[fi.rd] : '0;
                exp_rs.op_class = fi.op_class;
                exp_rs.src1_tag = fi.uses_rs1 ? spec_map[fi.rs1] : '0;
                exp_rs.src1_ready = !fi.uses_rs1;
                exp_rs.src2_tag = fi.uses_rs2 ? spec_map[fi.rs2] : '0;
                exp_rs.src2_ready = !fi.uses_rs2;
                exp_rs.dest_tag = new_tag;
                exp_rs.rob_idx = model_tail;
                compare_rob_entry(rob_alloc[i], exp_rob, i);
                compare_rs_entry(rs_alloc[i], exp_rs, i);
                if (fi.uses_rd) begin
                    spec_map[fi.rd] = new_tag;
                    spec_ofs++;
                end
                rob_q.push_back(exp_rob);
                model_tail = model_tail + 1'b1;
            end
        end

        // Retire before the flush copy
        for (int k = 0; k < ret_n; k++) begin
            done = rob_q.pop_front();
            if (done.uses_rd) begin
                commit_map[done.arch_rd] = done.phys_rd;
                fl_q.push_back(done.prev_phys_rd);
                void'(fl_q.pop_front());
                spec_ofs--;
            end
            model_head = model_head + 1'b1;
        end
        if (mispredict) begin
            for (int r = 0; r < `ARCH_REGS; r++) begin
                spec_map[r] = commit_map[r];
            end
            spec_ofs = 0;
            rob_q.delete();
            model_tail = model_head;
        end
        // Fetch holds a stalled bundle until it goes out
        hold_bundle = exp_stall && !mispredict;
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        fetch_bundle_t nb;
        retire_bundle_t rb;
        rs_count_t rs_next;
        logic mp_next;
        rng_state = 53932;
        reset = 1'b1;
        fetch_bundle = '0;
        rs_free_slots = '0;
        retire_bundle = '0;
        mispredict = 1'b0;
        hold_bundle = 1'b0;
        ret_n = 0;
        // Identity map and tags 32 to 63 free after reset
        for (int r = 0; r < `ARCH_REGS; r++) begin
            spec_map[r] = phys_tag_t'(r);
            commit_map[r] = phys_tag_t'(r);
        end
        for (int i = 0; i < `PHYS_REGS - `ARCH_REGS; i++) begin
            fl_q.push_back(phys_tag_t'(`ARCH_REGS + i));
        end
        spec_ofs = 0;
        model_head = '0;
        model_tail = '0;

        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;

        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            if (hold_bundle) begin
                nb = fetch_bundle;
            end else begin
                random_bundle(nb);
            end
            rs_next = rs_count_t'(next_rand() % (`RS_SIZE + 1));
            mp_next = (next_rand() % 32) == 0;
            build_retire(rb, ret_n);
            @(posedge clock);
            fetch_bundle <= nb;
            rs_free_slots <= rs_next;
            retire_bundle <= rb;
            mispredict <= mp_next;
            // Outputs are combinational, settled by the falling edge
            @(negedge clock);
            check_cycle();
        end
        $display("Result: PASSED");
        $finish;
    end

    // Watchdog sized from the test length
    initial begin
        #((NUM_CYCLES + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        stop_with_failure("Watchdog expired before the test loop finished");
    end

endmodule

/* flist.f */
+incdir+hdl
hdl/rename_pkg.sv
hdl/map_table.sv
hdl/free_list.sv
hdl/rob_tracker.sv
hdl/dispatch_stage.sv
hdl/rename_top.sv
sim/rename_tb.sv

/* run.sh */
#!/bin/sh
# Compile the rename stage with its testbench and run it with Verilator
# The exit status is the simulator's, nonzero when the testbench fails
cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal --top-module rename_tb \
        -f flist.f -o rename_sim \
    && ./obj_dir/rename_sim \
    || exit 1
